//--- src/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// word width in bits
`define CACHE_DATA_W 32
// byte address width; the front end sees word addresses
`define CACHE_ADDR_W 16

// two ways, 16 sets, 4 words per line
`define CACHE_N_WAYS 2
`define CACHE_LINE_OFF_W 4 // set index bits
`define CACHE_WORD_OFF_W 2 // word offset bits

// write-through buffer holds 2**n entries
`define CACHE_WTBUF_DEPTH_W 2

`endif

//--- src/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

   // derived widths
   localparam int STRB_W      = `CACHE_DATA_W / 8;
   localparam int BYTE_OFF_W  = $clog2(STRB_W);
   localparam int WADDR_W     = `CACHE_ADDR_W - BYTE_OFF_W; // word address, 14 bits
   localparam int TAG_W       = WADDR_W - `CACHE_LINE_OFF_W - `CACHE_WORD_OFF_W;
   localparam int LINE_ADDR_W = WADDR_W - `CACHE_WORD_OFF_W; // tag + index
   localparam int ENTRY_W     = WADDR_W + `CACHE_DATA_W + STRB_W;

   typedef logic [`CACHE_DATA_W-1:0]     word_t;
   typedef logic [STRB_W-1:0]            strb_t;
   typedef logic [WADDR_W-1:0]           waddr_t;
   typedef logic [TAG_W-1:0]             tag_t;
   typedef logic [`CACHE_LINE_OFF_W-1:0] index_t;
   typedef logic [`CACHE_WORD_OFF_W-1:0] offset_t;
   typedef logic [LINE_ADDR_W-1:0]       line_addr_t;
   typedef logic [`CACHE_N_WAYS-1:0]     way_t;      // one-hot
   typedef logic [ENTRY_W-1:0]           wtbuf_entry_t; // {addr, data, strb}

   // controller FSM
   typedef enum logic [1:0] {
      S_IDLE,
      S_LOOKUP,
      S_WAIT_WTBUF, // drain writes before a refill
      S_REFILL
   } ctrl_state_t;

endpackage

//--- src/cache_ways.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ways
(
   input  logic               clk,
   input  logic               rst,
   input  logic               invalidate,
   input  cache_pkg::index_t  index,
   input  cache_pkg::offset_t offset,
   input  cache_pkg::tag_t    tag,
   input  cache_pkg::way_t    data_we,
   input  cache_pkg::strb_t   data_strb,
   input  cache_pkg::word_t   data_wdata,
   input  cache_pkg::way_t    tag_we,
   output cache_pkg::way_t    way_hit,
   output cache_pkg::word_t   hit_rdata
);

   localparam int N_SETS = 2**`CACHE_LINE_OFF_W;
   localparam int N_WORDS = N_SETS * 2**`CACHE_WORD_OFF_W; // words per way

   cache_pkg::word_t way_rdata [`CACHE_N_WAYS]; // addressed word of each way

   for (genvar w = 0; w < `CACHE_N_WAYS; w++)
   begin : g_way
      cache_pkg::tag_t  tag_mem  [N_SETS];
      cache_pkg::word_t data_mem [N_WORDS]; // indexed by {set, word}
      logic [N_SETS-1:0] valid_bits;

      // arrays, byte-wise write enables
      always_ff @(posedge clk)
      begin
         if (tag_we[w])
            tag_mem[index] <= tag;
         for (int b = 0; b < cache_pkg::STRB_W; b++)
            if (data_we[w] && data_strb[b])
               data_mem[{index, offset}][8*b +: 8] <= data_wdata[8*b +: 8];
      end

      always_ff @(posedge clk)
      begin
         if (rst || invalidate)
            valid_bits <= '0; // flush all lines
         else if (tag_we[w])
            valid_bits[index] <= 1'b1;
      end

      assign way_hit[w] = valid_bits[index] && (tag_mem[index] == tag);
      assign way_rdata[w] = data_mem[{index, offset}];
   end

   // and-or mux, at most one way hits
   always_comb
   begin
      hit_rdata = '0;
      for (int w = 0; w < `CACHE_N_WAYS; w++)
         hit_rdata = hit_rdata | (way_rdata[w] & {`CACHE_DATA_W{way_hit[w]}});
   end

endmodule

//--- src/plru_replacement.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module plru_replacement
(
   input  logic              clk,
   input  logic              rst,
   input  logic              invalidate,
   input  cache_pkg::index_t index,
   input  logic              touch_en,
   input  cache_pkg::way_t   touch_way,
   output cache_pkg::way_t   victim
);

   localparam int N_SETS = 2**`CACHE_LINE_OFF_W;

   cache_pkg::way_t mru_bits [N_SETS]; // one bit per way, set when used
   cache_pkg::way_t cur_bits;
   cache_pkg::way_t upd_bits;

   assign cur_bits = mru_bits[index];
   assign upd_bits = cur_bits | touch_way;

   // lowest way not recently used; scan down so the lowest index wins
   always_comb
   begin
      victim = '0;
      for (int w = `CACHE_N_WAYS - 1; w >= 0; w--)
         if (!cur_bits[w])
            victim = cache_pkg::way_t'(1) << w;
   end

   always_ff @(posedge clk)
   begin
      if (rst || invalidate)
      begin
         for (int s = 0; s < N_SETS; s++)
            mru_bits[s] <= '0;
      end
      else if (touch_en)
         // all ways marked means start a new round
         mru_bits[index] <= (&upd_bits) ? '0 : upd_bits;
   end

endmodule

//--- src/write_through_buffer.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module write_through_buffer
#(
   parameter int DEPTH_W = `CACHE_WTBUF_DEPTH_W
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    push,
   input  cache_pkg::wtbuf_entry_t push_entry,
   input  logic                    write_ready,
   output logic                    write_valid,
   output cache_pkg::waddr_t       write_addr,
   output cache_pkg::word_t        write_wdata,
   output cache_pkg::strb_t        write_wstrb,
   output logic                    full,
   output logic                    empty
);

   cache_pkg::wtbuf_entry_t mem [2**DEPTH_W];
   logic [DEPTH_W:0] wr_ptr; // extra msb tells full from empty
   logic [DEPTH_W:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign empty = (wr_ptr == rd_ptr);
   assign full = (wr_ptr[DEPTH_W] != rd_ptr[DEPTH_W]) &&
                 (wr_ptr[DEPTH_W-1:0] == rd_ptr[DEPTH_W-1:0]);

   assign do_push = push && !full;
   assign do_pop = write_valid && write_ready; // back end takes the head

   // head entry onto the write channel
   assign write_valid = !empty;
   assign {write_addr, write_wdata, write_wstrb} = mem[rd_ptr[DEPTH_W-1:0]];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr[DEPTH_W-1:0]] <= push_entry;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

//--- src/cache_control.sv
`timescale 1ns/1ps

module cache_control
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    valid,
   input  cache_pkg::waddr_t       addr,
   input  cache_pkg::word_t        wdata,
   input  cache_pkg::strb_t        wstrb,
   input  logic                    read_valid,
   input  cache_pkg::offset_t      read_addr,
   input  cache_pkg::word_t        read_rdata,
   input  cache_pkg::way_t         way_hit,
   input  cache_pkg::word_t        hit_rdata,
   input  cache_pkg::way_t         victim,
   input  logic                    wtbuf_full,
   input  logic                    wtbuf_empty,
   output cache_pkg::word_t        rdata,
   output logic                    ready,
   output logic                    read_hit,
   output logic                    read_miss,
   output logic                    write_hit,
   output logic                    write_miss,
   output logic                    replace_valid,
   output cache_pkg::line_addr_t   replace_addr,
   output cache_pkg::index_t       index,
   output cache_pkg::offset_t      offset,
   output cache_pkg::tag_t         tag,
   output cache_pkg::way_t         data_we,
   output cache_pkg::strb_t        data_strb,
   output cache_pkg::word_t        data_wdata,
   output cache_pkg::way_t         tag_we,
   output logic                    touch_en,
   output cache_pkg::way_t         touch_way,
   output logic                    push,
   output cache_pkg::wtbuf_entry_t push_entry
);

   cache_pkg::ctrl_state_t state;
   cache_pkg::ctrl_state_t state_nxt;
   cache_pkg::waddr_t      req_addr;  // captured request
   cache_pkg::word_t       req_wdata;
   cache_pkg::strb_t       req_wstrb;
   cache_pkg::offset_t     req_offset;
   cache_pkg::way_t        victim_reg; // way picked at the miss
   cache_pkg::word_t       refill_word; // requested word seen during refill
   logic                   refill_done; // high the cycle after the last word
   logic                   is_write;
   logic                   hit;

   // split the word address into tag / set / word
   assign {tag, index, req_offset} = req_addr;
   assign is_write = |req_wstrb; // zero strobes means read
   assign hit = |way_hit;

   assign replace_addr = {tag, index};
   assign push_entry = {req_addr, req_wdata, req_wstrb};
   // hit data straight from the arrays, refill data from the holding register
   assign rdata = (state == cache_pkg::S_LOOKUP) ? hit_rdata : refill_word;

   always_comb
   begin
      state_nxt = state;
      ready = 1'b0;
      read_hit = 1'b0;
      read_miss = 1'b0;
      write_hit = 1'b0;
      write_miss = 1'b0;
      replace_valid = 1'b0;
      offset = req_offset;
      data_we = '0;
      data_strb = req_wstrb;
      data_wdata = req_wdata;
      tag_we = '0;
      touch_en = 1'b0;
      touch_way = way_hit;
      push = 1'b0;
      case (state)
         cache_pkg::S_IDLE:
            if (valid)
               state_nxt = cache_pkg::S_LOOKUP;
         cache_pkg::S_LOOKUP:
            if (!is_write)
            begin
               if (hit)
               begin
                  ready = 1'b1;
                  read_hit = 1'b1;
                  touch_en = 1'b1;
                  state_nxt = cache_pkg::S_IDLE;
               end
               else
               begin
                  read_miss = 1'b1;
                  state_nxt = cache_pkg::S_WAIT_WTBUF;
               end
            end
            else if (!wtbuf_full) // full buffer holds the write here
            begin
               push = 1'b1;
               ready = 1'b1;
               write_hit = hit;
               write_miss = !hit; // no allocate on write miss
               data_we = way_hit; // update bytes only in the hitting way
               touch_en = hit;
               state_nxt = cache_pkg::S_IDLE;
            end
         cache_pkg::S_WAIT_WTBUF:
            // pending writes go out before the line is fetched
            if (wtbuf_empty)
            begin
               replace_valid = 1'b1;
               state_nxt = cache_pkg::S_REFILL;
            end
         cache_pkg::S_REFILL:
            if (refill_done)
            begin
               ready = 1'b1;
               touch_en = 1'b1;
               touch_way = victim_reg;
               state_nxt = cache_pkg::S_IDLE;
            end
            else if (read_valid)
            begin
               offset = read_addr; // words arrive 0..3
               data_we = victim_reg;
               data_strb = '1;
               data_wdata = read_rdata;
               if (&read_addr)
                  tag_we = victim_reg; // tag and valid bit on the last word
            end
         default:
            state_nxt = cache_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= cache_pkg::S_IDLE;
         refill_done <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         refill_done <= (state == cache_pkg::S_REFILL) && !refill_done &&
                        read_valid && (&read_addr);
      end
   end

   // request and refill payload
   always_ff @(posedge clk)
   begin
      if (state == cache_pkg::S_IDLE && valid)
      begin
         req_addr <= addr;
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
      if (state == cache_pkg::S_LOOKUP && !is_write && !hit)
         victim_reg <= victim;
      if (state == cache_pkg::S_REFILL && !refill_done && read_valid && read_addr == req_offset)
         refill_word <= read_rdata; // keep the word the requester asked for
   end

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top
(
   input  logic                  clk,
   input  logic                  rst,
   // front end
   input  logic                  valid,
   input  cache_pkg::waddr_t     addr,
   input  cache_pkg::word_t      wdata,
   input  cache_pkg::strb_t      wstrb,
   output cache_pkg::word_t      rdata,
   output logic                  ready,
   // back-end write channel
   output logic                  write_valid,
   output cache_pkg::waddr_t     write_addr,
   output cache_pkg::word_t      write_wdata,
   output cache_pkg::strb_t      write_wstrb,
   input  logic                  write_ready,
   // back-end read channel
   output logic                  replace_valid,
   output cache_pkg::line_addr_t replace_addr,
   input  logic                  read_valid,
   input  cache_pkg::offset_t    read_addr,
   input  cache_pkg::word_t      read_rdata,
   // control and status
   input  logic                  invalidate,
   output logic                  wtbuf_full,
   output logic                  wtbuf_empty,
   output logic                  read_hit,
   output logic                  read_miss,
   output logic                  write_hit,
   output logic                  write_miss
);

   // controller <-> way arrays
   cache_pkg::index_t       index;
   cache_pkg::offset_t      offset;
   cache_pkg::tag_t         tag;
   cache_pkg::way_t         data_we;
   cache_pkg::strb_t        data_strb;
   cache_pkg::word_t        data_wdata;
   cache_pkg::way_t         tag_we;
   cache_pkg::way_t         way_hit;
   cache_pkg::word_t        hit_rdata;
   // controller <-> replacement
   logic                    touch_en;
   cache_pkg::way_t         touch_way;
   cache_pkg::way_t         victim;
   // controller -> write-through buffer
   logic                    push;
   cache_pkg::wtbuf_entry_t push_entry;

   cache_control u_control
   (
      .clk           (clk),
      .rst           (rst),
      .valid         (valid),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .way_hit       (way_hit),
      .hit_rdata     (hit_rdata),
      .victim        (victim),
      .wtbuf_full    (wtbuf_full),
      .wtbuf_empty   (wtbuf_empty),
      .rdata         (rdata),
      .ready         (ready),
      .read_hit      (read_hit),
      .read_miss     (read_miss),
      .write_hit     (write_hit),
      .write_miss    (write_miss),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .index         (index),
      .offset        (offset),
      .tag           (tag),
      .data_we       (data_we),
      .data_strb     (data_strb),
      .data_wdata    (data_wdata),
      .tag_we        (tag_we),
      .touch_en      (touch_en),
      .touch_way     (touch_way),
      .push          (push),
      .push_entry    (push_entry)
   );

   cache_ways u_ways
   (
      .clk        (clk),
      .rst        (rst),
      .invalidate (invalidate),
      .index      (index),
      .offset     (offset),
      .tag        (tag),
      .data_we    (data_we),
      .data_strb  (data_strb),
      .data_wdata (data_wdata),
      .tag_we     (tag_we),
      .way_hit    (way_hit),
      .hit_rdata  (hit_rdata)
   );

   plru_replacement u_plru
   (
      .clk        (clk),
      .rst        (rst),
      .invalidate (invalidate),
      .index      (index),
      .touch_en   (touch_en),
      .touch_way  (touch_way),
      .victim     (victim)
   );

   write_through_buffer u_wtbuf
   (
      .clk         (clk),
      .rst         (rst),
      .push        (push),
      .push_entry  (push_entry),
      .write_ready (write_ready),
      .write_valid (write_valid),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .full        (wtbuf_full),
      .empty       (wtbuf_empty)
   );

endmodule

//--- verification/cache_properties.sv
`timescale 1ns/1ps

module cache_properties
(
   input logic            clk,
   input logic            rst,
   input logic            ready,
   input logic            replace_valid,
   input logic            wtbuf_empty,
   input cache_pkg::way_t data_we,
   input cache_pkg::way_t tag_we
);

   int unsigned assert_errs = 0; // failed assertion count

   // ready is a single-cycle pulse
   ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
      else
      begin
         $error("ready high in two consecutive cycles");
         assert_errs++;
      end

   // line fetch only after all pending writes left
   refill_after_drain: assert property (@(posedge clk) disable iff (rst)
                                        replace_valid |-> wtbuf_empty)
      else
      begin
         $error("replace_valid while the write buffer holds entries");
         assert_errs++;
      end

   data_we_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(data_we))
      else
      begin
         $error("data_we selects more than one way");
         assert_errs++;
      end

   tag_we_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(tag_we))
      else
      begin
         $error("tag_we selects more than one way");
         assert_errs++;
      end

endmodule

bind cache_control cache_properties u_props
(
   .clk           (clk),
   .rst           (rst),
   .ready         (ready),
   .replace_valid (replace_valid),
   .wtbuf_empty   (wtbuf_empty),
   .data_we       (data_we),
   .tag_we        (tag_we)
);

//--- verification/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

   localparam int MAX_PAT = 64;
   localparam int N_COL = 6; // op, addr, wdata, strb, rdata, hit
   localparam logic [3:0] OP_READ = 4'h0;
   localparam logic [3:0] OP_WRITE = 4'h1;
   localparam logic [3:0] OP_INVAL = 4'h2;
   localparam logic [3:0] OP_STALL = 4'h3; // hold write_ready low from here on
   localparam logic [3:0] OP_BLOCKED = 4'h4; // write into a full buffer, then release
   localparam logic [3:0] OP_END = 4'hf;

   logic clk;
   logic rst;
   logic valid;
   cache_pkg::waddr_t addr;
   cache_pkg::word_t wdata;
   cache_pkg::strb_t wstrb;
   cache_pkg::word_t rdata;
   logic ready;
   logic write_valid;
   cache_pkg::waddr_t write_addr;
   cache_pkg::word_t write_wdata;
   cache_pkg::strb_t write_wstrb;
   logic write_ready;
   logic replace_valid;
   cache_pkg::line_addr_t replace_addr;
   logic read_valid;
   cache_pkg::offset_t read_addr;
   cache_pkg::word_t read_rdata;
   logic invalidate;
   logic wtbuf_full;
   logic wtbuf_empty;
   logic read_hit;
   logic read_miss;
   logic write_hit;
   logic write_miss;

   logic [31:0] pat_mem [N_COL*MAX_PAT];
   cache_pkg::word_t mem_model [2**cache_pkg::WADDR_W]; // word-addressed back-end memory
   cache_pkg::wtbuf_entry_t exp_writes [$]; // writes not yet seen on the back end
   int err_cnt;
   int n_pat;
   int cycle_cnt;
   int cycle_limit;
   logic limit_set;
   logic stall;
   logic [31:0] wr_rng;
   logic [31:0] gap_rng;

   cache_top dut0
   (
      .clk           (clk),
      .rst           (rst),
      .valid         (valid),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .rdata         (rdata),
      .ready         (ready),
      .write_valid   (write_valid),
      .write_addr    (write_addr),
      .write_wdata   (write_wdata),
      .write_wstrb   (write_wstrb),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .invalidate    (invalidate),
      .wtbuf_full    (wtbuf_full),
      .wtbuf_empty   (wtbuf_empty),
      .read_hit      (read_hit),
      .read_miss     (read_miss),
      .write_hit     (write_hit),
      .write_miss    (write_miss)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // random write_ready on the back-end write channel unless stalled
   initial
   begin
      wr_rng = 32'd78;
      forever
      begin
         @(posedge clk);
         #2;
         wr_rng = xorshift(wr_rng);
         write_ready = !stall && wr_rng[3];
      end
   end

   // compare each accepted write with the oldest one issued, then merge into memory
   task automatic accept_write();
      cache_pkg::wtbuf_entry_t exp;
      if (exp_writes.size() == 0)
      begin
         $display("unexpected write to %h on the back-end channel", write_addr);
         err_cnt++;
      end
      else
      begin
         exp = exp_writes.pop_front();
         if (write_addr !== exp[49:36])
            report_mismatch("write_addr", write_addr, exp[49:36]);
         if (write_wdata !== exp[35:4])
            report_mismatch("write_wdata", write_wdata, exp[35:4]);
         if (write_wstrb !== exp[3:0])
            report_mismatch("write_wstrb", write_wstrb, exp[3:0]);
      end
      for (int b = 0; b < cache_pkg::STRB_W; b++)
         if (write_wstrb[b])
            mem_model[write_addr][8*b +: 8] = write_wdata[8*b +: 8];
   endtask

   initial
   begin
      forever
      begin
         @(negedge clk);
         if (!rst && write_valid && write_ready)
            accept_write();
      end
   end

   // refill responder returns four words in order with random one-cycle gaps
   initial
   begin
      cache_pkg::line_addr_t line;
      gap_rng = 32'd78;
      forever
      begin
         @(negedge clk);
         if (replace_valid)
         begin
            line = replace_addr;
            for (int k = 0; k < 4; k++)
            begin
               @(posedge clk);
               #2;
               gap_rng = xorshift(gap_rng);
               if (gap_rng[0])
               begin
                  read_valid = 1'b0; // idle cycle between words
                  @(posedge clk);
                  #2;
               end
               read_valid = 1'b1;
               read_addr = cache_pkg::offset_t'(k);
               read_rdata = mem_model[{line, cache_pkg::offset_t'(k)}];
            end
            @(posedge clk);
            #2;
            read_valid = 1'b0;
         end
      end
   end

   task automatic run_access(input int idx, input logic [3:0] op, input cache_pkg::waddr_t a,
                             input cache_pkg::word_t wd, input cache_pkg::strb_t st,
                             input cache_pkg::word_t exp_rd, input logic exp_hit);
      logic is_write;
      logic saw_hit;
      logic saw_miss;
      logic done;
      int n_repl;
      int exp_repl;
      int wait_cyc;
      int errs_before;
      cache_pkg::word_t got_rd;
      string kind;
      string verdict;
      is_write = (op == OP_WRITE) || (op == OP_BLOCKED);
      if (is_write)
         kind = "write";
      else
         kind = "read";
      errs_before = err_cnt;
      saw_hit = 1'b0;
      saw_miss = 1'b0;
      done = 1'b0;
      n_repl = 0;
      wait_cyc = 0;
      got_rd = '0;
      @(posedge clk);
      #2;
      valid = 1'b1;
      addr = a;
      wdata = wd;
      wstrb = is_write ? st : '0;
      if (is_write)
         exp_writes.push_back({a, wd, st});
      while (!done)
      begin
         @(negedge clk);
         wait_cyc++;
         if (op == OP_BLOCKED && wait_cyc <= 8)
         begin
            if (ready)
            begin
               $display("ready given while the write buffer is full");
               err_cnt++;
            end
            if (wait_cyc == 8)
            begin
               if (wtbuf_full !== 1'b1)
                  report_mismatch("wtbuf_full", wtbuf_full, 1);
               if (wtbuf_empty !== 1'b0)
                  report_mismatch("wtbuf_empty", wtbuf_empty, 0);
               stall = 1'b0; // let the buffer drain
            end
         end
         if (is_write ? write_hit : read_hit)
            saw_hit = 1'b1;
         if (is_write ? write_miss : read_miss)
            saw_miss = 1'b1;
         if (replace_valid)
         begin
            n_repl++;
            if (replace_addr !== a[13:2])
               report_mismatch("replace_addr", replace_addr, a[13:2]);
         end
         if (ready)
         begin
            done = 1'b1;
            got_rd = rdata; // read data is valid only in the ready cycle
         end
      end
      @(posedge clk);
      #2;
      valid = 1'b0;
      wstrb = '0;
      exp_repl = (!is_write && !exp_hit) ? 1 : 0; // one line fetch per read miss
      if (saw_hit !== exp_hit)
         report_mismatch({kind, "_hit"}, saw_hit, exp_hit);
      if (saw_miss !== !exp_hit)
         report_mismatch({kind, "_miss"}, saw_miss, !exp_hit);
      if (!is_write && got_rd !== exp_rd)
         report_mismatch("rdata", got_rd, exp_rd);
      if (n_repl != exp_repl)
      begin
         $display("%0d replace_valid strobes seen where %0d were expected", n_repl, exp_repl);
         err_cnt++;
      end
      if (err_cnt == errs_before)
         verdict = "ok";
      else
         verdict = "failed";
      $display("pattern %0d %s %h %s", idx, kind, a, verdict);
   endtask

   task automatic play_pattern(input int idx);
      int base;
      logic [3:0] op;
      base = N_COL * idx;
      op = pat_mem[base][3:0];
      case (op)
         OP_INVAL:
         begin
            @(posedge clk);
            #2;
            invalidate = 1'b1;
            @(posedge clk);
            #2;
            invalidate = 1'b0;
            $display("pattern %0d invalidate", idx);
         end
         OP_STALL:
         begin
            @(negedge clk);
            stall = 1'b1; // write_ready drops at the next drive point
            @(posedge clk);
            #2;
            $display("pattern %0d hold write_ready low", idx);
         end
         default:
            run_access(idx, op, pat_mem[base+1][13:0], pat_mem[base+2],
                       pat_mem[base+3][3:0], pat_mem[base+4], pat_mem[base+5][0]);
      endcase
   endtask

   // whole-run limit of reset plus a budget per pattern
   initial
   begin
      cycle_cnt = 0;
      wait (limit_set);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("run stopped by timeout after %0d cycles", cycle_cnt);
      $display("Errors found");
      $finish;
   end

   initial
   begin
      int total;
      valid = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      write_ready = 1'b0;
      read_valid = 1'b0;
      read_addr = '0;
      read_rdata = '0;
      invalidate = 1'b0;
      rst = 1'b1;
      stall = 1'b0;
      err_cnt = 0;
      limit_set = 1'b0;
      for (int a = 0; a < 2**cache_pkg::WADDR_W; a++)
         mem_model[a] = {16'hc0de, 2'b00, cache_pkg::waddr_t'(a)}; // word = c0de + address
      $readmemh("verification/cache_patterns.txt", pat_mem);
      n_pat = 0;
      while (n_pat < MAX_PAT && pat_mem[N_COL*n_pat][3:0] != OP_END)
         n_pat++;
      cycle_limit = 16 + 60 * n_pat;
      limit_set = 1'b1;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      if (wtbuf_empty !== 1'b1) // buffer comes out of reset empty
         report_mismatch("wtbuf_empty", wtbuf_empty, 1);
      for (int i = 0; i < n_pat; i++)
         play_pattern(i);
      stall = 1'b0;
      // every issued write must reach the back end
      while (exp_writes.size() != 0 || !wtbuf_empty)
         @(negedge clk);
      total = err_cnt + dut0.u_control.u_props.assert_errs;
      $display("%0d patterns run, %0d errors", n_pat, total);
      if (total == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- verification/cache_patterns.txt
// columns: op addr wdata strb rdata hit, all hex; addr is a word address
// op 0 read, 1 write, 2 invalidate, 3 hold write_ready low, 4 write into full buffer, f end
0 0044 00000000 0 c0de0044 0
0 0047 00000000 0 c0de0047 1
1 0045 11223344 3 00000000 1
0 0045 00000000 0 c0de3344 1
1 0085 aabbccdd c 00000000 0
0 0085 00000000 0 aabb0085 0
// three tags in set 1
0 0044 00000000 0 c0de0044 1
0 00c4 00000000 0 c0de00c4 0
0 0086 00000000 0 c0de0086 0
0 00c7 00000000 0 c0de00c7 1
0 0045 00000000 0 c0de3344 0
0 0087 00000000 0 c0de0087 0
// fill the write buffer with write_ready low
3 0000 00000000 0 00000000 0
1 0100 01010101 f 00000000 0
1 0101 02020202 1 00000000 0
1 0044 03030303 8 00000000 1
1 0102 04040404 6 00000000 0
4 0103 05050505 f 00000000 0
0 0044 00000000 0 03de0044 1
0 0101 00000000 0 c0de0102 0
0 0102 00000000 0 c0040402 1
0 0103 00000000 0 05050505 1
0 0100 00000000 0 01010101 1
// flush, then cached lines miss again
2 0000 00000000 0 00000000 0
0 0044 00000000 0 03de0044 0
0 0100 00000000 0 01010101 0
0 0045 00000000 0 c0de3344 1
f 0000 00000000 0 00000000 0

//--- vlog.f
+incdir+src
src/cache_pkg.sv
src/cache_ways.sv
src/plru_replacement.sv
src/write_through_buffer.sv
src/cache_control.sv
src/cache_top.sv
verification/cache_properties.sv
verification/tb_cache.sv

//--- Bender.yml
package:
  name: cache_core

sources:
  - include_dirs:
      - src
    files:
      - src/cache_pkg.sv
      - src/cache_ways.sv
      - src/plru_replacement.sv
      - src/write_through_buffer.sv
      - src/cache_control.sv
      - src/cache_top.sv
  - target: test
    files:
      - verification/cache_properties.sv
      - verification/tb_cache.sv
